// ==== Bender.yml ====
package:
  name: decode

sources:
  - verilog/decode_pkg.sv
  - verilog/fetch_latch.sv
  - verilog/pc_imm_calc.sv
  - verilog/decode_riscv.sv
  - verilog/uop_out_reg.sv
  - verilog/decode_top.sv
  - target: test
    files:
      - bench/decode_asserts.sv
      - bench/decode_tb.sv

// ==== bench/decode_asserts.sv ====
`timescale 1ns/1ps

module decode_asserts(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic fetch_valid,
	input logic uop_valid
);

	// output stage empties on reset
	assert property (@(posedge clk) reset |=> !uop_valid)
		else $error("uop_valid high in the cycle after reset");

	// two stage latency when nothing flushes the insn
	assert property (@(posedge clk) disable iff (reset)
		(fetch_valid && !flush) ##1 !flush |=> uop_valid)
		else $error("accepted fetch did not reach the output two cycles later");

	// flush empties both stages
	assert property (@(posedge clk) disable iff (reset)
		flush |=> !uop_valid ##1 !uop_valid)
		else $error("uop_valid high within two cycles after a flush");

endmodule

bind decode_top decode_asserts decode_asserts_inst (.*);

// ==== bench/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb;
	import decode_pkg::*;

	localparam int n_kinds = 15;
	localparam int n_per_pass = 150;
	localparam int num_tests = 2 * n_per_pass;
	localparam int watchdog_ns = (num_tests + 20) * 4;

	localparam op_t load_ops [8] = '{LB, LH, LW, LD, LBU, LHU, II, II};
	localparam op_t store_ops [8] = '{SB, SH, SW, SD, II, II, II, II};
	localparam op_t imm_ops [8] = '{ADDI, SLLI, SLTI, SLTIU, XORI, II, ORI, ANDI};
	localparam op_t reg_ops [8] = '{ADDU, SLL, SLT, SLTU, XOR, SRL, OR, AND};
	localparam op_t mul_ops [8] = '{MUL, MULH, II, MULHU, DIV, DIVU, REM, REMU};
	localparam op_t br_ops [8] = '{BEQ, BNE, II, II, BLT, BGE, BLTU, BGEU};

	typedef struct packed {
		fetch_bundle_t bundle;
		logic mode64;
	} pending_t;

	logic clk = 1'b0;
	logic reset;
	logic mode64;
	logic flush;
	logic fetch_valid;
	fetch_bundle_t fetch;
	logic uop_valid;
	uop_t uop;

	pending_t pending [$]; // accepted, not yet seen at the output
	pending_t entry;
	logic exp_dec_valid = 1'b0;
	logic exp_valid = 1'b0;

	decode_top decode_top_inst (
		.clk(clk),
		.reset(reset),
		.mode64(mode64),
		.flush(flush),
		.fetch_valid(fetch_valid),
		.fetch(fetch),
		.uop_valid(uop_valid),
		.uop(uop)
	);

	initial
	begin
		forever #2 clk = ~clk;
	end

	task automatic stop_on_error();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_uop(input uop_t got, input uop_t exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: uop got %h (%s) expected %h (%s)", $time,
				got, got.op.name(), exp, exp.op.name());
			stop_on_error();
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: uop_valid got %b expected %b", $time, got, exp);
			stop_on_error();
		end
	endtask

	function automatic word_t pc_rel_expect(input insn_t w, input word_t pc, input logic m64);
		word_t off;
		word_t sum;
		case (opcode_t'(w[6:0]))
			opc_auipc: off = {{(m_width-32){w[31]}}, w[31:12], 12'd0};
			opc_branch: off = {{(m_width-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			opc_jal: off = {{(m_width-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default: off = '0;
		endcase
		sum = pc + off;
		return m64 ? sum : {{(m_width-32){sum[31]}}, sum[31:0]}; // rv32 fold
	endfunction

	function automatic op_t alu_expect(input insn_t w);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = w[14:12];
		f7 = w[31:25];
		case (opcode_t'(w[6:0]))
			opc_imm:
			begin
				if (f3 != 3'd5)
					return imm_ops[f3];
				if (f7 == 7'h00)
					return SRLI;
				return (f7 == 7'h20) ? SRAI : II;
			end
			opc_imm32: return (f3 == 3'd0) ? ADDIW : (f3 == 3'd1) ? SLLIW :
				(f3 == 3'd5) ? SRAIW : II;
			opc_reg:
			begin
				case (f7)
					7'h00: return reg_ops[f3];
					7'h20: return (f3 == 3'd0) ? SUBU : (f3 == 3'd5) ? SRA : II;
					7'h01: return mul_ops[f3];
					default: return II;
				endcase
			end
			opc_reg32: return (f3 == 3'd0 && f7 == 7'h00) ? ADDW : II;
			default: return II;
		endcase
	endfunction

	function automatic uop_t decode_expect(input fetch_bundle_t b, input logic m64);
		uop_t u;
		insn_t w;
		logic [2:0] f3;
		preg_t rd;
		preg_t rs1;
		preg_t rs2;
		word_t imm_i;
		op_t alu;
		op_t cnt;
		logic reg_op;
		w = b.insn;
		f3 = w[14:12];
		rd = preg_t'(w[11:7]);
		rs1 = preg_t'(w[19:15]);
		rs2 = preg_t'(w[24:20]);
		imm_i = {{(m_width-12){w[31]}}, w[31:20]};
		reg_op = w[5]; // register forms have opcode bit 5 set
		u = '0;
		u.op = II;
		u.pc = b.pc;
		u.pht_idx = b.pht_idx;
		case (opcode_t'(w[6:0]))
			opc_load, opc_store:
			begin
				u.op = reg_op ? store_ops[f3] : load_ops[f3];
				u.src_a = rs1;
				u.src_a_valid = 1'b1;
				u.src_b = reg_op ? rs2 : '0;
				u.src_b_valid = reg_op;
				u.dst = reg_op ? '0 : rd;
				u.dst_valid = !reg_op && (rd != 0);
				u.imm = reg_op ? {{(m_width-12){w[31]}}, w[31:25], w[11:7]} : imm_i;
				u.is_mem = 1'b1;
				u.is_store = reg_op;
			end
			opc_fence: u.op = NOP;
			opc_imm, opc_imm32, opc_reg, opc_reg32:
			begin
				alu = alu_expect(w);
				u.op = (alu != II && rd == 0) ? NOP : alu;
				u.src_a = rs1;
				u.src_a_valid = reg_op || (rd != 0);
				u.src_b = reg_op ? rs2 : '0;
				u.src_b_valid = reg_op;
				u.dst = rd;
				u.dst_valid = (rd != 0);
				u.imm = reg_op ? '0 : imm_i;
				u.is_int = 1'b1;
				u.is_cheap_int = (alu != II) &&
					!(alu inside {MUL, MULH, MULHU, DIV, DIVU, REM, REMU});
			end
			opc_lui, opc_auipc:
			begin
				u.op = (rd == 0) ? NOP : (w[5] ? LUI : AUIPC);
				u.dst = rd;
				u.dst_valid = (rd != 0);
				u.imm = w[5] ? {{(m_width-32){w[31]}}, w[31:12], 12'd0} :
					pc_rel_expect(w, b.pc, m64);
				u.is_int = 1'b1;
				u.is_cheap_int = 1'b1;
			end
			opc_branch:
			begin
				u.op = br_ops[f3];
				u.src_a = rs1;
				u.src_a_valid = 1'b1;
				u.src_b = rs2;
				u.src_b_valid = 1'b1;
				u.imm = pc_rel_expect(w, b.pc, m64);
				u.br_pred = b.pred;
				u.is_br = 1'b1;
				u.is_int = 1'b1;
				u.is_cheap_int = 1'b1;
			end
			opc_jalr:
			begin
				u.op = (rd != 0) ? JALR : ((rs1 == 1 || rs1 == 5) ? RET : JR);
				u.src_a = rs1;
				u.src_a_valid = 1'b1;
				u.dst = rd;
				u.dst_valid = (rd != 0);
				u.imm = imm_i;
				u.pred_target = b.pred_target;
				u.br_pred = 1'b1;
				u.is_br = 1'b1;
				u.is_int = 1'b1;
				u.is_cheap_int = 1'b1;
			end
			opc_jal:
			begin
				u.op = (rd == 0) ? J : JAL;
				u.dst = rd;
				u.dst_valid = (rd != 0);
				u.imm = pc_rel_expect(w, b.pc, m64);
				u.br_pred = 1'b1;
				u.is_br = 1'b1;
				u.is_int = 1'b1;
				u.is_cheap_int = (rd != 0);
			end
			opc_system:
			begin
				u.op = NOP;
				u.is_int = 1'b1;
				case (w[31:20])
					12'hc00: cnt = RDCYCLE;
					12'hc02: cnt = RDINSTRET;
					12'hc03: cnt = RDBRANCH;
					12'hc80: cnt = m64 ? II : RDCYCLEH; // 32-bit reads only
					12'hc82: cnt = m64 ? II : RDINSTRETH;
					12'hc04: cnt = m64 ? II : RDFAULTEDBRANCH;
					default: cnt = NOP;
				endcase
				if (w[31:7] == '0)
				begin
					u.op = BREAK;
					u.serializing = 1'b1;
				end
				else if (w[31:7] == {12'd1, 13'd0})
				begin
					u.op = MONITOR;
					u.serializing = 1'b1;
					u.must_restart = 1'b1;
				end
				else if (f3 == 3'd2 && cnt == II)
					u.op = II;
				else if (f3 == 3'd2 && cnt != NOP)
				begin
					u.op = (rd == 0) ? NOP : cnt;
					u.dst = rd;
					u.dst_valid = (rd != 0);
					u.serializing = 1'b1;
				end
			end
			default: u.op = II;
		endcase
		return u;
	endfunction

	function automatic insn_t make_insn(input int kind);
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [11:0] imm12;
		logic [19:0] imm20;
		csr_t csr;
		rd = ($urandom_range(3) == 0) ? 5'd0 : 5'($urandom);
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		f3 = 3'($urandom);
		imm12 = 12'($urandom);
		imm20 = 20'($urandom);
		case ($urandom_range(3))
			0, 1: f7 = 7'h00;
			2: f7 = 7'h20;
			default: f7 = 7'h01; // mul/div group
		endcase
		case ($urandom_range(2))
			0: csr = (kind == 10) ? 12'd1 : csr_cycle;
			1: csr = (kind == 10) ? 12'd5 : csr_t'(12'hc80 + 12'($urandom_range(4)));
			default: csr = 12'($urandom);
		endcase
		case (kind)
			0: return {imm12, rs1, f3, rd, opc_load};
			1: return {imm12[11:5], rs2, rs1, f3, imm12[4:0], opc_store};
			2: return {f7, rs2, rs1, f3, rd, opc_imm};
			3: return {f7, rs2, rs1, f3, rd, opc_imm32};
			4: return {f7, rs2, rs1, f3, rd, opc_reg};
			5: return {f7, rs2, rs1, 3'd0, rd, opc_reg32};
			6: return {imm20, rd, opc_lui};
			7: return {imm20, rd, opc_auipc};
			8: return {imm12[11:5], rs2, rs1, f3, imm12[4:0], opc_branch};
			9: return {imm20, rd, opc_jal};
			10: return {imm12, csr[4:0], 3'd0, rd, opc_jalr}; // rs1 often x1 or x5
			11: return {4'd0, 8'($urandom), 13'd0, opc_fence};
			12: return $urandom_range(1) ? 32'h0000_0073 : 32'h0010_0073;
			13: return {($urandom_range(1) ? csr_t'(12'hc00 + 12'($urandom_range(4))) : csr),
				5'd0, 3'd2, rd, opc_system};
			default: return $urandom;
		endcase
	endfunction

	task automatic drive_cycle(input logic fv, input logic fl, input fetch_bundle_t b);
		@(posedge clk);
		fetch_valid <= fv;
		flush <= fl;
		fetch <= b;
	endtask

	// reference pipeline, sampled before this edge's updates
	always @(posedge clk)
	begin
		exp_valid = !(reset || flush) && exp_dec_valid;
		if ((reset || flush) && exp_dec_valid)
			void'(pending.pop_back()); // insn latched one edge ago is dropped
		exp_dec_valid = !(reset || flush) && fetch_valid;
		if (exp_dec_valid)
			pending.push_back(pending_t'{bundle: fetch, mode64: mode64});
	end

	always @(negedge clk)
	begin
		check_valid(uop_valid, exp_valid);
		if (uop_valid)
		begin
			if (pending.size() == 0)
			begin
				$display("uop_valid at %0t with no instruction left to compare", $time);
				stop_on_error();
			end
			else
			begin
				entry = pending.pop_front();
				check_uop(uop, decode_expect(entry.bundle, entry.mode64));
			end
		end
	end

	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired before the test sequence finished");
		$display("Done: errors found");
		$fatal(1);
	end

	initial
	begin
		fetch_bundle_t b;
		int kind;
		reset = 1'b1;
		mode64 = 1'b1;
		flush = 1'b0;
		fetch_valid = 1'b0;
		fetch = '0;
		void'($urandom(32'h628c_2d4e));
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int pass = 0; pass < 2; pass++)
		begin
			@(posedge clk);
			fetch_valid <= 1'b0;
			flush <= 1'b0;
			@(posedge clk);
			mode64 <= (pass == 0); // pipeline idle while the mode changes
			for (int i = 0; i < n_per_pass; i++)
			begin
				kind = (i < 4 * n_kinds) ? i % n_kinds : $urandom_range(n_kinds - 1);
				b.insn = make_insn(kind);
				b.pc = {$urandom, $urandom};
				b.pred = 1'($urandom);
				b.pht_idx = pht_idx_t'($urandom);
				b.pred_target = {$urandom, $urandom};
				drive_cycle($urandom_range(7) != 0, $urandom_range(15) == 0, b);
			end
		end
		repeat (3) drive_cycle(1'b0, 1'b0, '0);
		@(negedge clk);
		if (pending.size() != 0)
		begin
			$display("%0d accepted instructions never reached the output", pending.size());
			stop_on_error();
		end
		else
		begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
verilog/decode_pkg.sv
verilog/fetch_latch.sv
verilog/pc_imm_calc.sv
verilog/decode_riscv.sv
verilog/uop_out_reg.sv
verilog/decode_top.sv
bench/decode_asserts.sv
bench/decode_tb.sv

// ==== verilog/decode_pkg.sv ====
package decode_pkg;

	localparam int m_width = 64;
	localparam int lg_prf_entries = 6;
	localparam int lg_pht_sz = 10;
	localparam int reg_pad = lg_prf_entries - 5; // zero bits above arch reg number

	typedef logic [m_width-1:0] word_t;
	typedef logic [31:0] insn_t;
	typedef logic [lg_prf_entries-1:0] preg_t;
	typedef logic [lg_pht_sz-1:0] pht_idx_t;
	typedef logic [6:0] opcode_t;
	typedef logic [11:0] csr_t;

	// major opcodes
	localparam opcode_t opc_load = 7'h03;
	localparam opcode_t opc_fence = 7'h0f;
	localparam opcode_t opc_imm = 7'h13;
	localparam opcode_t opc_auipc = 7'h17;
	localparam opcode_t opc_imm32 = 7'h1b;
	localparam opcode_t opc_store = 7'h23;
	localparam opcode_t opc_reg = 7'h33;
	localparam opcode_t opc_lui = 7'h37;
	localparam opcode_t opc_reg32 = 7'h3b;
	localparam opcode_t opc_branch = 7'h63;
	localparam opcode_t opc_jalr = 7'h67;
	localparam opcode_t opc_jal = 7'h6f;
	localparam opcode_t opc_system = 7'h73;

	// counter csr numbers
	localparam csr_t csr_cycle = 12'hc00;
	localparam csr_t csr_instret = 12'hc02;
	localparam csr_t csr_branch = 12'hc03;
	localparam csr_t csr_faultedbranch = 12'hc04; // rv32 only
	localparam csr_t csr_cycleh = 12'hc80;
	localparam csr_t csr_instreth = 12'hc82;

	typedef enum logic [6:0] {
		II,
		NOP,
		LB, LH, LW, LD, LBU, LHU,
		SB, SH, SW, SD,
		ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
		ADDIW, SLLIW, SRAIW,
		ADDU, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
		MUL, MULH, MULHU, DIV, DIVU, REM, REMU,
		ADDW,
		LUI, AUIPC,
		BEQ, BNE, BLT, BGE, BLTU, BGEU,
		J, JAL, JR, JALR, RET,
		BREAK, MONITOR,
		RDCYCLE, RDCYCLEH, RDINSTRET, RDINSTRETH, RDBRANCH, RDFAULTEDBRANCH
	} op_t;

	typedef struct packed {
		insn_t insn;
		word_t pc;
		logic pred; // predicted taken
		pht_idx_t pht_idx;
		word_t pred_target;
	} fetch_bundle_t;

	typedef struct packed {
		op_t op;
		preg_t src_a;
		preg_t src_b;
		preg_t dst;
		logic src_a_valid;
		logic src_b_valid;
		logic dst_valid;
		word_t imm; // decoded or pc-relative
		word_t pred_target;
		word_t pc;
		pht_idx_t pht_idx;
		logic br_pred;
		logic is_br;
		logic is_mem;
		logic is_store;
		logic is_int;
		logic is_cheap_int;
		logic serializing;
		logic must_restart;
	} uop_t;

endpackage

// ==== verilog/decode_riscv.sv ====
`timescale 1ns/1ps

module decode_riscv(
	input logic mode64,
	input decode_pkg::fetch_bundle_t fetch,
	output decode_pkg::uop_t uop
);
	import decode_pkg::*;

	insn_t insn;
	opcode_t opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	preg_t rd;
	preg_t rs1;
	preg_t rs2;
	word_t i_imm;
	word_t s_imm;
	word_t u_imm;
	word_t pc_rel;
	op_t base_op;
	op_t cnt_op;
	logic rs1_is_link;
	logic reg_form;

	assign insn = fetch.insn;
	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];
	assign rd = {{reg_pad{1'b0}}, insn[11:7]};
	assign rs1 = {{reg_pad{1'b0}}, insn[19:15]};
	assign rs2 = {{reg_pad{1'b0}}, insn[24:20]};
	assign i_imm = {{(m_width-12){insn[31]}}, insn[31:20]};
	assign s_imm = {{(m_width-12){insn[31]}}, insn[31:25], insn[11:7]};
	assign u_imm = {{(m_width-32){insn[31]}}, insn[31:12], 12'd0};
	assign rs1_is_link = (rs1 == 'd1) || (rs1 == 'd5); // ra or t0
	assign reg_form = (opcode == opc_reg) || (opcode == opc_reg32);

	pc_imm_calc pc_imm_calc_inst (
		.insn(insn),
		.pc(fetch.pc),
		.mode64(mode64),
		.target(pc_rel)
	);

	// op selection by funct fields
	always_comb
	begin
		base_op = II;
		case (opcode)
			opc_load:
			begin
				case (funct3)
					3'd0: base_op = LB;
					3'd1: base_op = LH;
					3'd2: base_op = LW;
					3'd3: base_op = LD;
					3'd4: base_op = LBU;
					3'd5: base_op = LHU;
					default: base_op = II;
				endcase
			end
			opc_store:
			begin
				case (funct3)
					3'd0: base_op = SB;
					3'd1: base_op = SH;
					3'd2: base_op = SW;
					3'd3: base_op = SD;
					default: base_op = II;
				endcase
			end
			opc_imm:
			begin
				case (funct3)
					3'd0: base_op = ADDI;
					3'd1: base_op = SLLI;
					3'd2: base_op = SLTI;
					3'd3: base_op = SLTIU;
					3'd4: base_op = XORI;
					3'd5:
					begin
						if (funct7 == 7'h00)
							base_op = SRLI;
						else if (funct7 == 7'h20)
							base_op = SRAI;
					end
					3'd6: base_op = ORI;
					3'd7: base_op = ANDI;
				endcase
			end
			opc_imm32:
			begin
				case (funct3)
					3'd0: base_op = ADDIW;
					3'd1: base_op = SLLIW;
					3'd5: base_op = SRAIW;
					default: base_op = II;
				endcase
			end
			opc_reg:
			begin
				case ({funct7, funct3})
					{7'h00, 3'd0}: base_op = ADDU;
					{7'h20, 3'd0}: base_op = SUBU;
					{7'h00, 3'd1}: base_op = SLL;
					{7'h00, 3'd2}: base_op = SLT;
					{7'h00, 3'd3}: base_op = SLTU;
					{7'h00, 3'd4}: base_op = XOR;
					{7'h00, 3'd5}: base_op = SRL;
					{7'h20, 3'd5}: base_op = SRA;
					{7'h00, 3'd6}: base_op = OR;
					{7'h00, 3'd7}: base_op = AND;
					{7'h01, 3'd0}: base_op = MUL;
					{7'h01, 3'd1}: base_op = MULH;
					{7'h01, 3'd3}: base_op = MULHU;
					{7'h01, 3'd4}: base_op = DIV;
					{7'h01, 3'd5}: base_op = DIVU;
					{7'h01, 3'd6}: base_op = REM;
					{7'h01, 3'd7}: base_op = REMU;
					default: base_op = II;
				endcase
			end
			opc_reg32:
			begin
				if (funct3 == 3'd0 && funct7 == 7'h00)
					base_op = ADDW;
			end
			opc_branch:
			begin
				case (funct3)
					3'd0: base_op = BEQ;
					3'd1: base_op = BNE;
					3'd4: base_op = BLT;
					3'd5: base_op = BGE;
					3'd6: base_op = BLTU;
					3'd7: base_op = BGEU;
					default: base_op = II;
				endcase
			end
			default: base_op = II;
		endcase
	end

	always_comb
	begin
		case (insn[31:20])
			csr_cycle: cnt_op = RDCYCLE;
			csr_instret: cnt_op = RDINSTRET;
			csr_branch: cnt_op = RDBRANCH;
			csr_cycleh: cnt_op = mode64 ? II : RDCYCLEH; // rv32 only
			csr_instreth: cnt_op = mode64 ? II : RDINSTRETH;
			csr_faultedbranch: cnt_op = mode64 ? II : RDFAULTEDBRANCH;
			default: cnt_op = NOP; // other csrs ignored
		endcase
	end

	always_comb
	begin
		uop = '0;
		uop.op = II;
		uop.pc = fetch.pc;
		uop.pht_idx = fetch.pht_idx;
		case (opcode)
			opc_load:
			begin
				uop.op = base_op;
				uop.src_a = rs1;
				uop.src_a_valid = 1'b1;
				uop.dst = rd;
				uop.dst_valid = (rd != '0);
				uop.imm = i_imm;
				uop.is_mem = 1'b1;
			end
			opc_store:
			begin
				uop.op = base_op;
				uop.src_a = rs1;
				uop.src_a_valid = 1'b1;
				uop.src_b = rs2;
				uop.src_b_valid = 1'b1;
				uop.imm = s_imm;
				uop.is_mem = 1'b1;
				uop.is_store = 1'b1;
			end
			opc_fence: uop.op = NOP;
			opc_imm, opc_imm32, opc_reg, opc_reg32:
			begin
				uop.op = (base_op != II && rd == '0) ? NOP : base_op;
				uop.src_a = rs1;
				uop.src_a_valid = reg_form || (rd != '0);
				uop.src_b = reg_form ? rs2 : '0;
				uop.src_b_valid = reg_form;
				uop.dst = rd;
				uop.dst_valid = (rd != '0);
				uop.imm = reg_form ? '0 : i_imm;
				uop.is_int = 1'b1;
				uop.is_cheap_int = (base_op != II) && !(reg_form && funct7 == 7'h01); // not mul/div
			end
			opc_lui, opc_auipc:
			begin
				uop.op = (rd == '0) ? NOP : ((opcode == opc_lui) ? LUI : AUIPC);
				uop.dst = rd;
				uop.dst_valid = (rd != '0);
				uop.imm = (opcode == opc_lui) ? u_imm : pc_rel;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
			end
			opc_branch:
			begin
				uop.op = base_op;
				uop.src_a = rs1;
				uop.src_a_valid = 1'b1;
				uop.src_b = rs2;
				uop.src_b_valid = 1'b1;
				uop.imm = pc_rel;
				uop.br_pred = fetch.pred;
				uop.is_br = 1'b1;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
			end
			opc_jalr:
			begin
				uop.op = (rd != '0) ? JALR : (rs1_is_link ? RET : JR);
				uop.src_a = rs1;
				uop.src_a_valid = 1'b1;
				uop.dst = rd;
				uop.dst_valid = (rd != '0);
				uop.imm = i_imm;
				uop.pred_target = fetch.pred_target; // target comes from the predictor
				uop.br_pred = 1'b1;
				uop.is_br = 1'b1;
				uop.is_int = 1'b1;
				uop.is_cheap_int = 1'b1;
			end
			opc_jal:
			begin
				uop.op = (rd == '0) ? J : JAL;
				uop.dst = rd;
				uop.dst_valid = (rd != '0);
				uop.imm = pc_rel;
				uop.br_pred = 1'b1;
				uop.is_br = 1'b1;
				uop.is_int = 1'b1;
				uop.is_cheap_int = (rd != '0); // plain j stays off the cheap path
			end
			opc_system:
			begin
				uop.op = NOP;
				uop.is_int = 1'b1;
				if (insn[31:7] == '0)
				begin
					uop.op = BREAK;
					uop.serializing = 1'b1;
				end
				else if (insn[31:20] == 12'd1 && insn[19:7] == '0)
				begin
					uop.op = MONITOR;
					uop.serializing = 1'b1;
					uop.must_restart = 1'b1;
				end
				else if (funct3 == 3'd2 && cnt_op == II)
				begin
					uop.op = II;
				end
				else if (funct3 == 3'd2 && cnt_op != NOP)
				begin
					uop.op = (rd == '0) ? NOP : cnt_op;
					uop.dst = rd;
					uop.dst_valid = (rd != '0);
					uop.serializing = 1'b1;
				end
			end
			default: uop.op = II;
		endcase
	end

endmodule

// ==== verilog/decode_top.sv ====
`timescale 1ns/1ps

module decode_top(
	input logic clk,
	input logic reset,
	input logic mode64,
	input logic flush,
	input logic fetch_valid,
	input decode_pkg::fetch_bundle_t fetch,
	output logic uop_valid,
	output decode_pkg::uop_t uop
);
	import decode_pkg::*;

	fetch_bundle_t dec_in;
	logic dec_valid;
	uop_t dec_uop;

	fetch_latch fetch_latch_inst (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.fetch_valid(fetch_valid),
		.fetch(fetch),
		.dec_valid(dec_valid),
		.dec_in(dec_in)
	);

	decode_riscv decode_riscv_inst (
		.mode64(mode64),
		.fetch(dec_in),
		.uop(dec_uop)
	);

	uop_out_reg uop_out_reg_inst (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.dec_valid(dec_valid),
		.dec_uop(dec_uop),
		.uop_valid(uop_valid),
		.uop(uop)
	);

endmodule

// ==== verilog/fetch_latch.sv ====
`timescale 1ns/1ps

module fetch_latch(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic fetch_valid,
	input decode_pkg::fetch_bundle_t fetch,
	output logic dec_valid,
	output decode_pkg::fetch_bundle_t dec_in
);

	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			dec_valid <= 1'b0; // flush drops the latched insn
		end
		else
		begin
			dec_valid <= fetch_valid;
		end
	end

	// bundle only moves on a fetch strobe
	always_ff @(posedge clk)
	begin
		if (fetch_valid)
		begin
			dec_in <= fetch;
		end
	end

endmodule

// ==== verilog/pc_imm_calc.sv ====
`timescale 1ns/1ps

module pc_imm_calc(
	input decode_pkg::insn_t insn,
	input decode_pkg::word_t pc,
	input logic mode64,
	output decode_pkg::word_t target
);
	import decode_pkg::*;

	word_t offset;
	word_t sum;

	always_comb
	begin
		case (opcode_t'(insn[6:0]))
			opc_auipc:
				offset = {{(m_width-32){insn[31]}}, insn[31:12], 12'd0};
			opc_branch:
				offset = {{(m_width-13){insn[31]}}, insn[31], insn[7], insn[30:25],
					insn[11:8], 1'b0};
			opc_jal:
				offset = {{(m_width-21){insn[31]}}, insn[31], insn[19:12], insn[20],
					insn[30:21], 1'b0};
			default:
				offset = '0;
		endcase
	end

	assign sum = pc + offset;

	// rv32 keeps the sum as a sign-extended word
	assign target = mode64 ? sum : {{(m_width-32){sum[31]}}, sum[31:0]};

endmodule

// ==== verilog/uop_out_reg.sv ====
`timescale 1ns/1ps

module uop_out_reg(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic dec_valid,
	input decode_pkg::uop_t dec_uop,
	output logic uop_valid,
	output decode_pkg::uop_t uop
);

	// rename always accepts, so no stall path here
	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			uop_valid <= 1'b0;
		end
		else
		begin
			uop_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (dec_valid)
		begin
			uop <= dec_uop; // held until the next decoded insn
		end
	end

endmodule
